/* common/sdram_pkg.sv */
// widths, command encoding and mode register layout shared by the
// sdram controller and the behavioral memory model
// referenced by scoped name from each user
package sdram_pkg;

    localparam int ADDR_W = 13;
    localparam int BA_W   = 2;
    localparam int DQ_W   = 16;
    localparam int DQM_W  = 2;

    // {cs, ras, cas, we}, deselect is cs high
    typedef enum logic [3:0] {
        cmd_load_mode = 4'b0000,
        cmd_active    = 4'b0011,
        cmd_write     = 4'b0100,
        cmd_read      = 4'b0101,
        cmd_nop       = 4'b0111
    } sdram_cmd_e;

    localparam int MODE_CL_LSB = 4;   // cas latency in a[6:4]
    localparam int MODE_BL_LSB = 0;   // burst length in a[2:0]
    localparam int COL_HI_BIT  = 11;  // column is {a[11], a[9:0]}

endpackage

/* common/sdram_bus_if.sv */
// sdram pin bus between the controller and the memory model
// ctrl drives the command pins, dq is tristate with one driver at a time
`timescale 1ns/10ps

interface sdram_bus_if;

    logic                         cs;
    logic                         ras;
    logic                         cas;
    logic                         we;
    logic [sdram_pkg::ADDR_W-1:0] a;
    logic [sdram_pkg::BA_W-1:0]   ba;
    logic [sdram_pkg::DQM_W-1:0]  dqm;
    wire  [sdram_pkg::DQ_W-1:0]   dq;    // resolved net

    modport ctrl (
        output cs,
        output ras,
        output cas,
        output we,
        output a,
        output ba,
        output dqm,
        inout  dq
    );

    modport mem (
        input  cs,
        input  ras,
        input  cas,
        input  we,
        input  a,
        input  ba,
        input  dqm,
        inout  dq
    );

endinterface

/* sdram_ctrl/sdram_timer.sv */
// down-counter for command spacing and burst beats
// done is high for one cycle, load cycles after the start edge
`timescale 1ns/10ps

module sdram_timer #(
    parameter int CNT_W = 4
) (
    input  logic             clk,
    input  logic             cke,
    input  logic             start,
    input  logic [CNT_W-1:0] load,
    output logic             done
);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= load;              // restarts a running count
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign done = (cnt == CNT_W'(1));

    a_done_pulse: assert property (@(posedge clk) disable iff (!cke)
        done |=> !done);

endmodule

/* sdram_ctrl/sdram_datapath.sv */
// write beats onto dq and read beats into the burst result
// the fsm supplies the beat index and the drive and capture strobes
`timescale 1ns/10ps

module sdram_datapath #(
    parameter int BURST_LEN = 4
) (
    input  logic                                 clk,
    input  logic                                 cke,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0] wdata,
    input  logic                                 wr_beat,
    input  logic                                 rd_capture,
    input  logic [$clog2(BURST_LEN)-1:0]         beat,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0] rdata,
    sdram_bus_if.ctrl                            bus
);

    localparam int DQ_W = sdram_pkg::DQ_W;

    assign bus.dq = wr_beat ? wdata[beat*DQ_W +: DQ_W] : 'z;

    always_ff @(posedge clk) begin
        if (rd_capture) begin
            rdata[beat*DQ_W +: DQ_W] <= bus.dq;   // slot held until next read
        end
    end

    a_no_drive_on_read: assert property (@(posedge clk) disable iff (!cke)
        rd_capture |-> !wr_beat);

endmodule

/* sdram_ctrl/sdram_ctrl_fsm.sv */
// controller state machine: programs the mode register after reset, then
// runs one activate plus read or write burst per four-phase req/ack transfer
// T_RCD must be 2 or more, the rcd count starts with the activate
`timescale 1ns/10ps

module sdram_ctrl_fsm #(
    parameter int T_RCD     = 2,
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 4,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 5,
    parameter int TMR_W     = 4
) (
    input  logic                         clk,
    input  logic                         cke,
    input  logic                         req,
    input  logic                         wr,
    input  logic [sdram_pkg::BA_W-1:0]   addr_bank,
    input  logic [ROW_W-1:0]             addr_row,
    input  logic [COL_W-1:0]             addr_col,
    input  logic [sdram_pkg::DQM_W-1:0]  wmask,
    output logic                         ack,
    output logic                         tmr_start,
    output logic [TMR_W-1:0]             tmr_load,
    input  logic                         tmr_done,
    output logic                         wr_beat,
    output logic                         rd_capture,
    output logic [$clog2(BURST_LEN)-1:0] beat,
    sdram_bus_if.ctrl                    bus
);

    localparam int ADDR_W = sdram_pkg::ADDR_W;
    localparam logic [ADDR_W-1:0] MODE_A = (ADDR_W'(CAS_LAT) << sdram_pkg::MODE_CL_LSB)
                                         | (ADDR_W'(BURST_LEN) << sdram_pkg::MODE_BL_LSB);

    typedef enum logic [3:0] {
        init_mode,
        idle,
        activate,
        wait_rcd,
        write_burst,
        read_wait,
        read_burst,
        done,
        ack_release   // ack already low, one cycle before idle
    } state_e;

    state_e                       state;
    logic [3:0]                   cmd_q;
    logic [ADDR_W-1:0]            a_q;
    logic [sdram_pkg::BA_W-1:0]   ba_q;
    logic [sdram_pkg::DQM_W-1:0]  dqm_q;
    logic [10:0]                  col_ext;
    logic [ADDR_W-1:0]            col_a;
    logic                         cmd_live;

    assign col_ext = 11'(addr_col);

    always_comb begin
        col_a = '0;
        col_a[9:0] = col_ext[9:0];
        col_a[sdram_pkg::COL_HI_BIT] = col_ext[10];
    end

    // timer is restarted on the edge that leaves each timed phase
    always_comb begin
        tmr_start = 1'b0;
        tmr_load  = TMR_W'(T_RCD);
        case (state)
            idle: begin
                tmr_start = req;
            end
            wait_rcd: begin
                tmr_start = tmr_done;
                tmr_load  = wr ? TMR_W'(BURST_LEN) : TMR_W'(CAS_LAT);
            end
            read_wait: begin
                tmr_start = tmr_done;
                tmr_load  = TMR_W'(BURST_LEN);
            end
            default: begin
                tmr_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state      <= init_mode;
            cmd_q      <= 4'b1111;    // deselect
            a_q        <= '0;
            ba_q       <= '0;
            dqm_q      <= '1;
            ack        <= 1'b0;
            wr_beat    <= 1'b0;
            rd_capture <= 1'b0;
            beat       <= '0;
        end else begin
            cmd_q <= sdram_pkg::cmd_nop;
            case (state)
                init_mode: begin
                    cmd_q <= sdram_pkg::cmd_load_mode;
                    a_q   <= MODE_A;
                    state <= idle;
                end
                idle: begin
                    if (req) begin
                        cmd_q <= sdram_pkg::cmd_active;
                        a_q   <= ADDR_W'(addr_row);
                        ba_q  <= addr_bank;
                        state <= activate;
                    end
                end
                activate: begin
                    state <= wait_rcd;
                end
                wait_rcd: begin
                    if (tmr_done) begin
                        a_q  <= col_a;
                        beat <= '0;
                        if (wr) begin
                            cmd_q   <= sdram_pkg::cmd_write;
                            dqm_q   <= wmask;
                            wr_beat <= 1'b1;     // beat 0 goes out with the command
                            state   <= write_burst;
                        end else begin
                            cmd_q <= sdram_pkg::cmd_read;
                            dqm_q <= '0;
                            state <= read_wait;
                        end
                    end
                end
                write_burst: begin
                    if (tmr_done) begin
                        wr_beat <= 1'b0;
                        ack     <= 1'b1;
                        state   <= done;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                read_wait: begin
                    if (tmr_done) begin
                        rd_capture <= 1'b1;
                        state      <= read_burst;
                    end
                end
                read_burst: begin
                    if (tmr_done) begin
                        rd_capture <= 1'b0;       // last beat lands on this edge
                        ack        <= 1'b1;
                        state      <= done;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                done: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ack_release;
                    end
                end
                ack_release: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    assign bus.cs  = cmd_q[3];
    assign bus.ras = cmd_q[2];
    assign bus.cas = cmd_q[1];
    assign bus.we  = cmd_q[0];
    assign bus.a   = a_q;
    assign bus.ba  = ba_q;
    assign bus.dqm = dqm_q;

    assign cmd_live = !cmd_q[3] && (cmd_q != sdram_pkg::cmd_nop);

    a_ack_after_req: assert property (@(posedge clk) disable iff (!cke)
        $rose(ack) |-> $past(req));

    // a command shows only on the cycle a new state is entered
    a_one_cmd_per_state: assert property (@(posedge clk) disable iff (!cke)
        cmd_live |-> state != $past(state));

endmodule

/* sdram_model/sdram_model.sv */
// behavioral sdram: mode register, one open row, burst read and write
// with per-byte write masks, answers commands on the shared pin bus
`timescale 1ns/10ps

module sdram_model #(
    parameter int ROW_W = 4,
    parameter int COL_W = 5
) (
    input  logic     clk,
    input  logic     cke,
    sdram_bus_if.mem bus
);

    localparam int DQ_W   = sdram_pkg::DQ_W;
    localparam int BA_W   = sdram_pkg::BA_W;
    localparam int DQM_W  = sdram_pkg::DQM_W;
    localparam int BYTE_W = DQ_W / DQM_W;

    logic [DQ_W-1:0]  ram [2**BA_W][2**ROW_W][2**COL_W];
    logic [3:0]       cmd;
    logic             is_load;
    logic             is_active;
    logic             is_read;
    logic             is_write;
    logic [10:0]      col_full;
    logic [COL_W-1:0] cmd_col;
    logic [COL_W-1:0] wr_col;
    logic             wr_hit;
    logic [2:0]       cas_lat_q;
    logic [2:0]       burst_q;
    logic [BA_W-1:0]  bank_q;
    logic [ROW_W-1:0] row_q;
    logic             row_open;
    logic [COL_W-1:0] col_q;
    logic             rd_pend;
    logic [2:0]       lat_cnt;
    logic [2:0]       rd_left;
    logic [2:0]       wr_left;
    logic             rd_oe;

    assign cmd       = {bus.cs, bus.ras, bus.cas, bus.we};
    assign is_load   = (cmd == sdram_pkg::cmd_load_mode);
    assign is_active = (cmd == sdram_pkg::cmd_active);
    assign is_read   = (cmd == sdram_pkg::cmd_read);
    assign is_write  = (cmd == sdram_pkg::cmd_write);

    assign col_full = {bus.a[sdram_pkg::COL_HI_BIT], bus.a[9:0]};
    assign cmd_col  = col_full[COL_W-1:0];

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cas_lat_q <= 3'd2;
            burst_q   <= 3'd1;
            bank_q    <= '0;
            row_q     <= '0;
            row_open  <= 1'b0;
            col_q     <= '0;
            rd_pend   <= 1'b0;
            lat_cnt   <= '0;
            rd_left   <= '0;
            wr_left   <= '0;
        end else begin
            if (is_load) begin
                cas_lat_q <= bus.a[sdram_pkg::MODE_CL_LSB +: 3];
                burst_q   <= bus.a[sdram_pkg::MODE_BL_LSB +: 3];  // word count
            end
            if (is_active) begin
                bank_q   <= bus.ba;
                row_q    <= bus.a[ROW_W-1:0];
                row_open <= 1'b1;
            end
            if (is_read) begin
                rd_pend <= 1'b1;
                lat_cnt <= cas_lat_q - 1'b1;
                rd_left <= burst_q;
                col_q   <= cmd_col;
            end else if (is_write) begin
                wr_left <= burst_q - 1'b1;     // beat 0 stored with the command
                col_q   <= cmd_col + 1'b1;
            end else if (rd_pend) begin
                if (lat_cnt != '0) begin
                    lat_cnt <= lat_cnt - 1'b1;
                end else begin
                    col_q   <= col_q + 1'b1;
                    rd_left <= rd_left - 1'b1;
                    if (rd_left == 3'd1) begin
                        rd_pend <= 1'b0;
                    end
                end
            end else if (wr_left != '0) begin
                wr_left <= wr_left - 1'b1;
                col_q   <= col_q + 1'b1;
            end
        end
    end

    assign wr_hit = is_write || (wr_left != '0);
    assign wr_col = is_write ? cmd_col : col_q;

    always_ff @(posedge clk) begin
        for (int b = 0; b < DQM_W; b++) begin
            if (wr_hit && !bus.dqm[b]) begin
                ram[bank_q][row_q][wr_col][b*BYTE_W +: BYTE_W] <= bus.dq[b*BYTE_W +: BYTE_W];
            end
        end
    end

    assign rd_oe  = rd_pend && (lat_cnt == '0);
    assign bus.dq = rd_oe ? ram[bank_q][row_q][col_q] : 'z;

    a_access_open_row: assert property (@(posedge clk) disable iff (!cke)
        (is_read || is_write) |-> row_open && (bus.ba == bank_q));

    a_no_cmd_in_burst: assert property (@(posedge clk) disable iff (!cke)
        (rd_pend || wr_left != '0) |-> !(is_load || is_active || is_read || is_write));

endmodule

/* rtl/sdram_subsys.sv */
// sdram subsystem top: controller fsm, timer and datapath driving the
// behavioral model over the pin bus, user side is a four-phase req/ack port
`timescale 1ns/10ps

module sdram_subsys #(
    parameter int T_RCD     = 2,
    parameter int CAS_LAT   = 2,
    parameter int BURST_LEN = 4,
    parameter int ROW_W     = 4,
    parameter int COL_W     = 5
) (
    input  logic                                 clk,
    input  logic                                 cke,
    input  logic                                 req,
    input  logic                                 wr,
    input  logic [sdram_pkg::BA_W-1:0]           addr_bank,
    input  logic [ROW_W-1:0]                     addr_row,
    input  logic [COL_W-1:0]                     addr_col,
    input  logic [sdram_pkg::DQM_W-1:0]          wmask,
    input  logic [BURST_LEN*sdram_pkg::DQ_W-1:0] wdata,
    output logic                                 ack,
    output logic [BURST_LEN*sdram_pkg::DQ_W-1:0] rdata
);

    localparam int TMR_W = $clog2(T_RCD + CAS_LAT + BURST_LEN + 1);

    logic                         tmr_start;
    logic [TMR_W-1:0]             tmr_load;
    logic                         tmr_done;
    logic                         wr_beat;
    logic                         rd_capture;
    logic [$clog2(BURST_LEN)-1:0] beat;

    sdram_bus_if u_bus ();

    sdram_ctrl_fsm #(
        .T_RCD     (T_RCD),
        .CAS_LAT   (CAS_LAT),
        .BURST_LEN (BURST_LEN),
        .ROW_W     (ROW_W),
        .COL_W     (COL_W),
        .TMR_W     (TMR_W)
    ) u_fsm (
        .clk        (clk),
        .cke        (cke),
        .req        (req),
        .wr         (wr),
        .addr_bank  (addr_bank),
        .addr_row   (addr_row),
        .addr_col   (addr_col),
        .wmask      (wmask),
        .ack        (ack),
        .tmr_start  (tmr_start),
        .tmr_load   (tmr_load),
        .tmr_done   (tmr_done),
        .wr_beat    (wr_beat),
        .rd_capture (rd_capture),
        .beat       (beat),
        .bus        (u_bus.ctrl)
    );

    sdram_timer #(
        .CNT_W (TMR_W)
    ) u_timer (
        .clk   (clk),
        .cke   (cke),
        .start (tmr_start),
        .load  (tmr_load),
        .done  (tmr_done)
    );

    sdram_datapath #(
        .BURST_LEN (BURST_LEN)
    ) u_datapath (
        .clk        (clk),
        .cke        (cke),
        .wdata      (wdata),
        .wr_beat    (wr_beat),
        .rd_capture (rd_capture),
        .beat       (beat),
        .rdata      (rdata),
        .bus        (u_bus.ctrl)
    );

    sdram_model #(
        .ROW_W (ROW_W),
        .COL_W (COL_W)
    ) u_model (
        .clk (clk),
        .cke (cke),
        .bus (u_bus.mem)
    );

endmodule

/* verif/tb_sdram_subsys.sv */
// directed testbench for the sdram subsystem, runs four-phase transfers and
// checks read data against a byte-wide shadow memory under a watchdog
`timescale 1ns/10ps

module tb_sdram_subsys;

    localparam int T_RCD     = 2;
    localparam int CAS_LAT   = 2;
    localparam int BURST_LEN = 4;
    localparam int ROW_W     = 4;
    localparam int COL_W     = 5;
    localparam int DQ_W      = sdram_pkg::DQ_W;
    localparam int BA_W      = sdram_pkg::BA_W;
    localparam int DQM_W     = sdram_pkg::DQM_W;
    localparam int BYTE_W    = DQ_W / DQM_W;
    localparam int BURST_W   = BURST_LEN * DQ_W;
    localparam int SLOTS     = 2**COL_W / BURST_LEN;
    localparam int ACK_WAIT  = 40;
    localparam int N_XFER    = 37;    // 2 + 2 + 3 + 6 + 24 transfers
    localparam int WATCHDOG_CYCLES = N_XFER * 40 + 200;

    logic               clk;
    logic               cke;
    logic               req;
    logic               wr;
    logic [BA_W-1:0]    addr_bank;
    logic [ROW_W-1:0]   addr_row;
    logic [COL_W-1:0]   addr_col;
    logic [DQM_W-1:0]   wmask;
    logic [BURST_W-1:0] wdata;
    logic               ack;
    logic [BURST_W-1:0] rdata;

    logic [BYTE_W-1:0] shadow [2**BA_W][2**ROW_W][2**COL_W][DQM_W];
    bit                burst_known [2**BA_W][2**ROW_W][SLOTS];
    int                known_keys [$];
    int                err_cnt;
    int                hs_err;

    sdram_subsys #(
        .T_RCD     (T_RCD),
        .CAS_LAT   (CAS_LAT),
        .BURST_LEN (BURST_LEN),
        .ROW_W     (ROW_W),
        .COL_W     (COL_W)
    ) u_dut (
        .clk       (clk),
        .cke       (cke),
        .req       (req),
        .wr        (wr),
        .addr_bank (addr_bank),
        .addr_row  (addr_row),
        .addr_col  (addr_col),
        .wmask     (wmask),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_word(input logic [DQ_W-1:0] got, input logic [DQ_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_burst(input logic [BURST_W-1:0] got, input logic [BURST_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic logic [BURST_W-1:0] expected_burst(input int bank, input int row,
                                                          input int col);
        logic [BURST_W-1:0] val;
        for (int k = 0; k < BURST_LEN; k++) begin
            for (int b = 0; b < DQM_W; b++) begin
                val[k*DQ_W + b*BYTE_W +: BYTE_W] = shadow[bank][row][col+k][b];
            end
        end
        return val;
    endfunction

    // masked bytes keep their old shadow value
    task automatic record_write(input int bank, input int row, input int col,
                                input logic [DQM_W-1:0] mask, input logic [BURST_W-1:0] data);
        for (int k = 0; k < BURST_LEN; k++) begin
            for (int b = 0; b < DQM_W; b++) begin
                if (!mask[b]) begin
                    shadow[bank][row][col+k][b] = data[k*DQ_W + b*BYTE_W +: BYTE_W];
                end
            end
        end
        if (!burst_known[bank][row][col/BURST_LEN]) begin
            burst_known[bank][row][col/BURST_LEN] = 1'b1;
            known_keys.push_back((bank * 2**ROW_W + row) * SLOTS + col / BURST_LEN);
        end
    endtask

    task automatic wait_ack(input logic want, input string what);
        int n;
        n = 0;
        while (ack !== want && n < ACK_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== want) begin
            $display("%0t: %s within %0d cycles", $time, what, ACK_WAIT);
            hs_err++;
        end
    endtask

    // ack must hold while req is high, fall after req drops and stay low
    task automatic close_handshake();
        if (ack === 1'b1) begin
            @(negedge clk);
            check_level(ack, 1'b1, "ack dropped while req still high");
        end
        req = 1'b0;
        wait_ack(1'b0, "ack did not fall after req dropped");
        @(negedge clk);
        check_level(ack, 1'b0, "ack rose while req low");
    endtask

    task automatic run_handshake(input bit is_wr, input int bank, input int row, input int col,
                                 input logic [DQM_W-1:0] mask, input logic [BURST_W-1:0] data,
                                 output logic [BURST_W-1:0] got);
        check_level(ack, 1'b0, "ack high before req");
        req       = 1'b1;
        wr        = is_wr;
        addr_bank = BA_W'(bank);
        addr_row  = ROW_W'(row);
        addr_col  = COL_W'(col);
        wmask     = mask;
        wdata     = data;
        wait_ack(1'b1, "the DUT gave no ack for a transfer");
        got = rdata;
        close_handshake();
    endtask

    task automatic do_write(input int bank, input int row, input int col,
                            input logic [DQM_W-1:0] mask, input logic [BURST_W-1:0] data);
        logic [BURST_W-1:0] unused;
        run_handshake(1'b1, bank, row, col, mask, data, unused);
        record_write(bank, row, col, mask, data);
    endtask

    task automatic do_read(input int bank, input int row, input int col,
                           output logic [BURST_W-1:0] got);
        run_handshake(1'b0, bank, row, col, '0, {$urandom, $urandom}, got);
    endtask

    // req is already up while cke is low, init has to finish first
    task automatic test_req_at_reset();
        logic [BURST_W-1:0] data;
        logic [BURST_W-1:0] got;
        data      = {$urandom, $urandom};
        cke       = 1'b0;
        req       = 1'b1;
        wr        = 1'b1;
        addr_bank = BA_W'(1);
        addr_row  = ROW_W'(2);
        addr_col  = COL_W'(4);
        wmask     = '0;
        wdata     = data;
        repeat (3) @(posedge clk);
        @(negedge clk);
        cke = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_level(ack, 1'b0, "ack during mode register init");
        end
        wait_ack(1'b1, "the DUT gave no ack for the write held across reset");
        close_handshake();
        record_write(1, 2, 4, '0, data);
        do_read(1, 2, 4, got);
        check_burst(got, expected_burst(1, 2, 4), "read after reset-time write");
    endtask

    task automatic test_plain_write_read();
        logic [BURST_W-1:0] data;
        logic [BURST_W-1:0] got;
        data = {$urandom, $urandom};
        do_write(1, 3, 8, '0, data);
        do_read(1, 3, 8, got);
        for (int k = 0; k < BURST_LEN; k++) begin
            check_word(got[k*DQ_W +: DQ_W], data[k*DQ_W +: DQ_W],
                       $sformatf("plain read beat %0d", k));
        end
    endtask

    task automatic test_masked_write();
        logic [BURST_W-1:0] first;
        logic [BURST_W-1:0] second;
        logic [BURST_W-1:0] merged;
        logic [BURST_W-1:0] got;
        first  = {$urandom, $urandom};
        second = {$urandom, $urandom};
        for (int k = 0; k < BURST_LEN; k++) begin
            merged[k*DQ_W +: DQ_W] = {second[k*DQ_W+BYTE_W +: BYTE_W], first[k*DQ_W +: BYTE_W]};
        end
        do_write(2, 5, 16, '0, first);
        do_write(2, 5, 16, 2'b01, second);    // low byte masked
        do_read(2, 5, 16, got);
        check_burst(got, merged, "masked write, high bytes only");
        check_burst(got, expected_burst(2, 5, 16), "masked write against shadow");
    endtask

    task automatic test_no_alias();
        int banks [3] = '{0, 3, 0};
        int rows [3]  = '{1, 1, 9};
        logic [BURST_W-1:0] got;
        for (int i = 0; i < 3; i++) begin
            do_write(banks[i], rows[i], 12, '0, {$urandom, $urandom});
        end
        for (int i = 0; i < 3; i++) begin
            do_read(banks[i], rows[i], 12, got);
            check_burst(got, expected_burst(banks[i], rows[i], 12),
                        $sformatf("alias check, bank %0d row %0d", banks[i], rows[i]));
        end
    endtask

    task automatic test_random_traffic();
        logic [BURST_W-1:0] got;
        logic [DQM_W-1:0]   mask;
        int                 bank;
        int                 row;
        int                 col;
        int                 key;
        for (int i = 0; i < 24; i++) begin
            if (known_keys.size() == 0 || $urandom % 2 == 1) begin
                bank = $urandom % 2**BA_W;
                row  = $urandom % 2**ROW_W;
                col  = ($urandom % SLOTS) * BURST_LEN;
                // a fresh burst gets every byte so its reads are fully known
                mask = burst_known[bank][row][col/BURST_LEN] ? DQM_W'($urandom) : '0;
                do_write(bank, row, col, mask, {$urandom, $urandom});
            end else begin
                key  = known_keys[$urandom % known_keys.size()];
                bank = key / (2**ROW_W * SLOTS);
                row  = (key / SLOTS) % 2**ROW_W;
                col  = (key % SLOTS) * BURST_LEN;
                do_read(bank, row, col, got);
                check_burst(got, expected_burst(bank, row, col),
                            $sformatf("random read %0d", i));
            end
        end
    endtask

    initial begin
        void'($urandom(36));
        err_cnt   = 0;
        hs_err    = 0;
        cke       = 1'b0;
        req       = 1'b0;
        wr        = 1'b0;
        addr_bank = '0;
        addr_row  = '0;
        addr_col  = '0;
        wmask     = '0;
        wdata     = '0;
        test_req_at_reset();
        test_plain_write_read();
        test_masked_write();
        test_no_alias();
        test_random_traffic();
        $display("errors: %0d value mismatches, %0d handshake failures", err_cnt, hs_err);
        if (err_cnt == 0 && hs_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* build.f */
common/sdram_pkg.sv
common/sdram_bus_if.sv
sdram_ctrl/sdram_timer.sv
sdram_ctrl/sdram_datapath.sv
sdram_ctrl/sdram_ctrl_fsm.sv
sdram_model/sdram_model.sv
rtl/sdram_subsys.sv
verif/tb_sdram_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_sdram_subsys -o tb_sdram_subsys > build.log 2>&1 \
    && ./obj_dir/tb_sdram_subsys > sim.log 2>&1 \
    && grep -qx "All checks passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
